/* bench/tb_clk_synth.sv */
`timescale 1ns/10ps

module tb_clk_synth;

    localparam int WW        = clk_synth_pkg::WORD_W;
    localparam int AW        = clk_synth_pkg::SLOT_ADDR_W;
    localparam int NUM_SLOTS = clk_synth_pkg::NUM_SLOTS;
    localparam int SYNC_LOW  = 5;
    localparam int QUIET_CYC = 100;

    typedef enum logic [1:0] {
        OP_WRITE,
        OP_READ,   // data holds the expected value
        OP_RUN,    // wait for a run and check words and sync
        OP_QUIET   // no frame and no sync for a window
    } op_t;

    typedef struct packed {
        op_t           op;
        logic [AW-1:0] addr;
        logic [WW-1:0] data;
    } step_t;

    logic          slow_clk;
    logic          resetS;
    logic          io_sel;
    logic          io_sync;
    logic [AW-1:0] io_addr;
    logic          io_wr_en;
    logic [WW-1:0] io_wr_data;
    logic          io_rd_en;
    logic [WW-1:0] io_rd_data;
    logic          io_rd_ack;
    logic          dclk;
    logic          ddat;
    logic          dlen;
    logic          sync;

    step_t         steps [$];
    logic [WW-1:0] run_exp [$];     // expected words of all runs in order
    logic [WW-1:0] model_slots [NUM_SLOTS];
    logic [WW-1:0] model_ctrl;
    logic [31:0]   lfsr_state = 32'hd938_18af;
    logic [WW-1:0] words_q [$];     // words seen on the serial lines
    int            sync_q [$];      // low lengths of sync pulses
    logic [WW-1:0] cur_word;
    int            cur_bits;
    int            sync_low;
    bit            mon_en;
    int            cycle_cnt;
    int            cycle_limit = 100000;

    clk_synth_top #(
        .SYNC_LOW_CYCLES (SYNC_LOW)
    ) dut_i (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .io_sel     (io_sel),
        .io_sync    (io_sync),
        .io_addr    (io_addr),
        .io_wr_en   (io_wr_en),
        .io_wr_data (io_wr_data),
        .io_rd_en   (io_rd_en),
        .io_rd_data (io_rd_data),
        .io_rd_ack  (io_rd_ack),
        .dclk       (dclk),
        .ddat       (ddat),
        .dlen       (dlen),
        .sync       (sync)
    );

    initial begin
        slow_clk = 1'b0;
        forever #4 slow_clk = ~slow_clk;
    end

    // ==============================
    // helpers
    // ==============================

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error at %0t: %s, got %h expected %h", $time, what, got, exp);
            $display("TEST RESULT: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic rand_word(output logic [WW-1:0] w);
        w = '0;
        for (int b = 0; b < WW; b++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[WW-2:0], lfsr_state[0]};  // one step per bit
        end
    endtask

    function automatic logic [WW-1:0] model_read(input logic [AW-1:0] addr);
        if (int'(addr) < NUM_SLOTS) begin
            return model_slots[int'(addr)];
        end else if (int'(addr) == clk_synth_pkg::CTRL_ADDR) begin
            return model_ctrl;
        end
        return '0;  // unmapped
    endfunction

    task automatic add_step(input op_t op, input logic [AW-1:0] addr,
                            input logic [WW-1:0] data);
        step_t s;
        s.op   = op;
        s.addr = addr;
        s.data = data;
        steps.push_back(s);
    endtask

    task automatic add_write(input int addr, input logic [WW-1:0] data);
        if (addr < NUM_SLOTS) begin
            model_slots[addr] = data;
        end else if (addr == clk_synth_pkg::CTRL_ADDR) begin
            model_ctrl = data;
        end
        add_step(OP_WRITE, AW'(addr), data);
    endtask

    task automatic add_read(input int addr);
        add_step(OP_READ, AW'(addr), model_read(AW'(addr)));
    endtask

    task automatic add_run();
        for (int i = 0; i < NUM_SLOTS; i++) begin
            run_exp.push_back(model_slots[i]);
        end
        add_step(OP_RUN, '0, '0);
    endtask

    // ==============================
    // stimulus table
    // ==============================

    task automatic build_table();
        logic [WW-1:0] w;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            model_slots[i] = clk_synth_pkg::CS_DEFAULTS[i];
        end
        model_ctrl = clk_synth_pkg::CTRL_DEFAULT;
        add_run();                            // default run after reset
        for (int a = 0; a <= NUM_SLOTS; a++) begin
            add_read(a);
        end
        add_read(30);
        for (int a = 0; a < NUM_SLOTS; a++) begin
            rand_word(w);
            add_write(a, w);
        end
        for (int a = 0; a < NUM_SLOTS; a++) begin
            add_read(a);
        end
        rand_word(w);
        add_write(28, w);                     // unmapped so the write is dropped
        for (int a = 0; a < 32; a++) begin
            add_read(a);
        end
        add_write(clk_synth_pkg::CTRL_ADDR, 32'h0);
        add_write(clk_synth_pkg::CTRL_ADDR, 32'h1);
        add_run();
        add_write(clk_synth_pkg::CTRL_ADDR, 32'h0);
        add_write(clk_synth_pkg::CTRL_ADDR, 32'h2);  // bit 0 stays low
        add_step(OP_QUIET, '0, '0);
        add_read(clk_synth_pkg::CTRL_ADDR);
    endtask

    // ==============================
    // bus and run tasks
    // ==============================

    task automatic bus_write(input logic [AW-1:0] addr, input logic [WW-1:0] data);
        io_sel     = 1'b1;
        io_sync    = 1'b1;
        io_wr_en   = 1'b1;
        io_addr    = addr;
        io_wr_data = data;
        @(negedge slow_clk);
        io_sel   = 1'b0;
        io_sync  = 1'b0;
        io_wr_en = 1'b0;
    endtask

    task automatic bus_read_check(input logic [AW-1:0] addr, input logic [WW-1:0] exp);
        check_value("rd_ack before request", 32'(io_rd_ack), 32'd0);
        io_sel   = 1'b1;
        io_sync  = 1'b1;
        io_rd_en = 1'b1;
        io_addr  = addr;
        @(negedge slow_clk);
        io_sel   = 1'b0;
        io_sync  = 1'b0;
        io_rd_en = 1'b0;
        check_value("rd_ack one cycle after request", 32'(io_rd_ack), 32'd1);
        check_value($sformatf("read data at address %0d", addr), io_rd_data, exp);
        @(negedge slow_clk);
        check_value("rd_ack held longer than one cycle", 32'(io_rd_ack), 32'd0);
    endtask

    task automatic expect_run();
        logic [WW-1:0] exp_w;
        while (sync_q.size() == 0) begin
            @(negedge slow_clk);
        end
        check_value("words in run", 32'(words_q.size()), 32'(NUM_SLOTS));
        for (int i = 0; i < NUM_SLOTS; i++) begin
            exp_w = run_exp.pop_front();
            check_value($sformatf("run word for slot %0d", i), words_q[i], exp_w);
        end
        check_value("sync low cycles", 32'(sync_q[0]), 32'(SYNC_LOW));
        words_q.delete();
        sync_q.delete();
    endtask

    task automatic expect_quiet(input int cycles);
        for (int c = 0; c < cycles; c++) begin
            @(negedge slow_clk);
            check_value("dlen without trigger", 32'(dlen), 32'd1);
            check_value("sync without trigger", 32'(sync), 32'd1);
        end
        check_value("words without trigger", 32'(words_q.size()), 32'd0);
    endtask

    // ==============================
    // serial monitor and watchdog
    // ==============================

    always @(negedge slow_clk) begin
        if (mon_en) begin
            if (!dlen) begin
                cur_word = {cur_word[WW-2:0], ddat};  // msb first
                cur_bits = cur_bits + 1;
            end else if (cur_bits != 0) begin
                check_value("bits per word", 32'(cur_bits), 32'(WW));
                words_q.push_back(cur_word);
                cur_bits = 0;
            end
            if (!sync) begin
                sync_low = sync_low + 1;
            end else if (sync_low != 0) begin
                sync_q.push_back(sync_low);
                sync_low = 0;
            end
        end
    end

    // dclk sampled 1 ns into each phase of slow_clk
    always @(negedge slow_clk) begin
        #1;
        check_value("dclk in low phase of slow_clk", 32'(dclk), 32'd1);
    end

    always @(posedge slow_clk) begin
        #1;
        check_value("dclk in high phase of slow_clk", 32'(dclk), 32'd0);
    end

    always @(posedge slow_clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: test still running after %0d cycles", cycle_limit);
            $display("TEST RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    // ==============================
    // main sequence
    // ==============================

    initial begin
        resetS     = 1'b1;
        io_sel     = 1'b0;
        io_sync    = 1'b0;
        io_addr    = '0;
        io_wr_en   = 1'b0;
        io_wr_data = '0;
        io_rd_en   = 1'b0;
        mon_en     = 1'b0;
        cur_word   = '0;
        cur_bits   = 0;
        sync_low   = 0;
        cycle_cnt  = 0;
        build_table();
        cycle_limit = 4 * (NUM_SLOTS * 40 + 50) + 4 * steps.size();

        repeat (3) begin
            @(negedge slow_clk);
            check_value("dlen in reset", 32'(dlen), 32'd1);
            check_value("sync in reset", 32'(sync), 32'd1);
            check_value("rd_ack in reset", 32'(io_rd_ack), 32'd0);
            check_value("ddat in reset", 32'(ddat), 32'd0);
        end
        resetS = 1'b0;
        mon_en = 1'b1;  // default run follows right away

        for (int i = 0; i < steps.size(); i++) begin
            case (steps[i].op)
                OP_WRITE: bus_write(steps[i].addr, steps[i].data);
                OP_READ:  bus_read_check(steps[i].addr, steps[i].data);
                OP_RUN:   expect_run();
                default:  expect_quiet(QUIET_CYC);
            endcase
        end

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

/* cfg_regs/synth_reg_bank.sv */
`timescale 1ns/10ps

module synth_reg_bank (
    input  logic                                  slow_clk,
    input  logic                                  resetS,
    input  logic                                  io_sel,
    input  logic                                  io_sync,
    input  logic [clk_synth_pkg::SLOT_ADDR_W-1:0] io_addr,
    input  logic                                  io_wr_en,
    input  logic [clk_synth_pkg::WORD_W-1:0]      io_wr_data,
    input  logic                                  io_rd_en,
    input  logic [clk_synth_pkg::SLOT_ADDR_W-1:0] slot_idx,
    output logic [clk_synth_pkg::WORD_W-1:0]      io_rd_data,
    output logic                                  io_rd_ack,
    output logic [clk_synth_pkg::WORD_W-1:0]      slot_word,
    output logic                                  prog_start
);

    localparam int AW = clk_synth_pkg::SLOT_ADDR_W;
    localparam int WW = clk_synth_pkg::WORD_W;
    localparam logic [AW-1:0] SLOT_END  = AW'(clk_synth_pkg::NUM_SLOTS);
    localparam logic [AW-1:0] CTRL_SLOT = AW'(clk_synth_pkg::CTRL_ADDR);

    logic [WW-1:0] slot_q [clk_synth_pkg::NUM_SLOTS];
    logic [WW-1:0] ctrl_q;           // bit 0 is the programming trigger
    logic          ctrl_bit_prev;
    logic          wr_req;
    logic          rd_req;
    logic [WW-1:0] rd_mux;

    assign wr_req = io_sel & io_sync & io_wr_en;
    assign rd_req = io_sel & io_sync & io_rd_en;

    // ==============================
    // slot and control storage
    // ==============================

    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            for (int i = 0; i < clk_synth_pkg::NUM_SLOTS; i++) begin
                slot_q[i] <= clk_synth_pkg::CS_DEFAULTS[i];
            end
            ctrl_q <= clk_synth_pkg::CTRL_DEFAULT;
        end else if (wr_req) begin
            if (io_addr < SLOT_END) begin
                slot_q[io_addr] <= io_wr_data;
            end else if (io_addr == CTRL_SLOT) begin
                ctrl_q <= io_wr_data;
            end
            // 27..31 fall through, write dropped
        end
    end

    // sequencer side, out-of-range index reads 0
    assign slot_word = (slot_idx < SLOT_END) ? slot_q[slot_idx] : '0;

    // ==============================
    // readback
    // ==============================

    always_comb begin
        if (io_addr < SLOT_END) begin
            rd_mux = slot_q[io_addr];
        end else if (io_addr == CTRL_SLOT) begin
            rd_mux = ctrl_q;
        end else begin
            rd_mux = '0;  // unmapped
        end
    end

    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            io_rd_ack <= 1'b0;
        end else begin
            io_rd_ack <= rd_req;  // always exactly one cycle later
        end
    end

    always_ff @(posedge slow_clk) begin
        if (rd_req) begin
            io_rd_data <= rd_mux;  // value before any write on the same edge
        end
    end

    // ==============================
    // trigger edge detect
    // ==============================

    // prev starts at 0 so the default control word fires a run after reset
    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            ctrl_bit_prev <= 1'b0;
            prog_start    <= 1'b0;
        end else begin
            ctrl_bit_prev <= ctrl_q[0];
            prog_start    <= ctrl_q[0] & ~ctrl_bit_prev;
        end
    end

    a_rd_ack_follows_req : assert property (
        @(posedge slow_clk) disable iff (resetS)
        io_rd_ack |-> $past(rd_req)
    );

endmodule

/* common/clk_synth_pkg.sv */
package clk_synth_pkg;

    // ==============================
    // widths and address map
    // ==============================

    localparam int WORD_W      = 32;  // synth word and bus data
    localparam int SLOT_ADDR_W = 5;   // bus address and slot index
    localparam int NUM_SLOTS   = 26;
    localparam int CTRL_ADDR   = 26;  // control register sits right after the slots

    localparam logic [WORD_W-1:0] CTRL_DEFAULT = 32'h0000_0001;

    // ==============================
    // default register images
    // ==============================

    // slot order is programming order, register number in bits 4:0
    localparam logic [WORD_W-1:0] CS_DEFAULTS [NUM_SLOTS] = '{
        32'h0002_0000,  // R0 with reset bit set
        32'h0014_0320,  // R0
        32'h0014_0301,  // R1
        32'h0014_0302,  // R2
        32'h0014_0303,  // R3
        32'h0014_0304,  // R4
        32'h0014_0305,  // R5
        32'h1100_0006,  // R6
        32'h1100_0007,  // R7
        32'h0100_0008,  // R8
        32'h5555_5549,  // R9
        32'h9102_410A,  // R10
        32'h0401_100B,  // R11
        32'h1B0C_006C,  // R12
        32'h2302_886D,  // R13
        32'h0200_000E,  // R14
        32'h8000_800F,  // R15
        32'hC155_0410,  // R16
        32'h0000_0018,  // R24
        32'h0000_0019,  // R25
        32'h8000_001A,  // R26
        32'h1000_003B,  // R27
        32'h0010_003C,  // R28
        32'h0078_003D,  // R29
        32'h0200_003E,  // R30
        32'h001F_001F   // R31, last word of a run
    };

endpackage

/* rtl/clk_synth_top.sv */
`timescale 1ns/10ps

module clk_synth_top #(
    parameter int SYNC_LOW_CYCLES = 16
) (
    input  logic                                  slow_clk,
    input  logic                                  resetS,
    input  logic                                  io_sel,
    input  logic                                  io_sync,
    input  logic [clk_synth_pkg::SLOT_ADDR_W-1:0] io_addr,
    input  logic                                  io_wr_en,
    input  logic [clk_synth_pkg::WORD_W-1:0]      io_wr_data,
    input  logic                                  io_rd_en,
    output logic [clk_synth_pkg::WORD_W-1:0]      io_rd_data,
    output logic                                  io_rd_ack,
    output logic                                  dclk,
    output logic                                  ddat,
    output logic                                  dlen,
    output logic                                  sync
);

    logic                                  prog_start;
    logic [clk_synth_pkg::SLOT_ADDR_W-1:0] slot_idx;
    logic [clk_synth_pkg::WORD_W-1:0]      slot_word;
    logic                                  word_load;
    logic [clk_synth_pkg::WORD_W-1:0]      load_word;
    logic                                  busy;

    // synth samples ddat on the opposite edge
    assign dclk = ~slow_clk;

    synth_reg_bank reg_bank_i (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .io_sel     (io_sel),
        .io_sync    (io_sync),
        .io_addr    (io_addr),
        .io_wr_en   (io_wr_en),
        .io_wr_data (io_wr_data),
        .io_rd_en   (io_rd_en),
        .slot_idx   (slot_idx),
        .io_rd_data (io_rd_data),
        .io_rd_ack  (io_rd_ack),
        .slot_word  (slot_word),
        .prog_start (prog_start)
    );

    program_sequencer #(
        .SYNC_LOW_CYCLES (SYNC_LOW_CYCLES)
    ) sequencer_i (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .prog_start (prog_start),
        .busy       (busy),
        .slot_word  (slot_word),
        .slot_idx   (slot_idx),
        .word_load  (word_load),
        .load_word  (load_word),
        .sync       (sync)
    );

    word_shifter shifter_i (
        .slow_clk  (slow_clk),
        .resetS    (resetS),
        .word_load (word_load),
        .load_word (load_word),
        .ddat      (ddat),
        .dlen      (dlen),
        .busy      (busy)
    );

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the clock synthesizer testbench with Verilator.
# Exit status is zero only when the simulation passes.

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_clk_synth
OBJ_DIR=obj_dir

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH" >&2
    exit 1
fi

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module "$TOP" \
    --Mdir "$OBJ_DIR" \
    -o "$TOP" \
    -f src.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status" >&2
    exit $status
fi

"./$OBJ_DIR/$TOP"
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status" >&2
    exit $status
fi

echo "simulation finished cleanly"
exit 0

/* serial/program_sequencer.sv */
`timescale 1ns/10ps

module program_sequencer #(
    parameter int SYNC_LOW_CYCLES = 16
) (
    input  logic                                  slow_clk,
    input  logic                                  resetS,
    input  logic                                  prog_start,
    input  logic                                  busy,
    input  logic [clk_synth_pkg::WORD_W-1:0]      slot_word,
    output logic [clk_synth_pkg::SLOT_ADDR_W-1:0] slot_idx,
    output logic                                  word_load,
    output logic [clk_synth_pkg::WORD_W-1:0]      load_word,
    output logic                                  sync
);

    localparam int AW   = clk_synth_pkg::SLOT_ADDR_W;
    localparam int SC_W = $clog2(SYNC_LOW_CYCLES) + 1;
    localparam logic [AW-1:0]   LAST_SLOT = AW'(clk_synth_pkg::NUM_SLOTS - 1);
    localparam logic [SC_W-1:0] SYNC_LAST = SC_W'(SYNC_LOW_CYCLES - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOAD,
        S_SHIFT_WAIT,
        S_NEXT,
        S_SYNC_LOW,
        S_SYNC_HIGH
    } seq_state_t;

    seq_state_t      state;
    logic [SC_W-1:0] sync_cnt;
    logic            restart_pend;  // trigger seen mid-run

    // word handed to the shifter together with the load strobe
    always_ff @(posedge slow_clk) begin
        if (state == S_LOAD) begin
            load_word <= slot_word;
        end
    end

    // ==============================
    // slot walk and sync
    // ==============================

    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            state        <= S_IDLE;
            slot_idx     <= '0;
            word_load    <= 1'b0;
            sync         <= 1'b1;
            sync_cnt     <= '0;
            restart_pend <= 1'b0;
        end else begin
            word_load <= 1'b0;  // single-cycle strobe
            case (state)
                S_IDLE: begin
                    if (prog_start || restart_pend) begin
                        slot_idx     <= '0;
                        restart_pend <= 1'b0;
                        state        <= S_LOAD;
                    end
                end
                S_LOAD: begin
                    word_load <= 1'b1;
                    state     <= S_SHIFT_WAIT;
                end
                S_SHIFT_WAIT: begin
                    // strobe cycle first, then the whole busy window
                    if (!word_load && !busy) begin
                        state <= S_NEXT;
                    end
                end
                S_NEXT: begin
                    if (restart_pend) begin
                        slot_idx     <= '0;  // start over from slot 0
                        restart_pend <= 1'b0;
                        state        <= S_LOAD;
                    end else if (slot_idx == LAST_SLOT) begin
                        sync     <= 1'b0;
                        sync_cnt <= '0;
                        state    <= S_SYNC_LOW;
                    end else begin
                        slot_idx <= slot_idx + 1'b1;
                        state    <= S_LOAD;
                    end
                end
                S_SYNC_LOW: begin
                    if (sync_cnt == SYNC_LAST) begin
                        sync  <= 1'b1;
                        state <= S_SYNC_HIGH;
                    end else begin
                        sync_cnt <= sync_cnt + 1'b1;
                    end
                end
                S_SYNC_HIGH: begin
                    slot_idx <= '0;  // run complete
                    state    <= S_IDLE;
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase

            if (prog_start && state != S_IDLE) begin
                restart_pend <= 1'b1;
            end
        end
    end

    a_slot_idx_range : assert property (
        @(posedge slow_clk) disable iff (resetS)
        slot_idx < AW'(clk_synth_pkg::NUM_SLOTS)
    );

endmodule

/* serial/word_shifter.sv */
`timescale 1ns/10ps

module word_shifter (
    input  logic                             slow_clk,
    input  logic                             resetS,
    input  logic                             word_load,
    input  logic [clk_synth_pkg::WORD_W-1:0] load_word,
    output logic                             ddat,
    output logic                             dlen,
    output logic                             busy
);

    localparam int WW    = clk_synth_pkg::WORD_W;
    localparam int CNT_W = $clog2(WW);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(WW - 1);

    logic [WW-1:0]    shift_q;
    logic [CNT_W-1:0] bit_cnt;  // bits already sent in this word

    // ==============================
    // data path
    // ==============================

    // msb first, shift only once dlen is low so bit 31 gets a full cycle
    always_ff @(posedge slow_clk) begin
        if (word_load) begin
            shift_q <= load_word;
        end else if (!dlen) begin
            shift_q <= {shift_q[WW-2:0], 1'b0};
        end
    end

    assign ddat = shift_q[WW-1] & ~dlen;  // line rests at 0 between words

    // ==============================
    // framing
    // ==============================

    always_ff @(posedge slow_clk) begin
        if (resetS) begin
            busy    <= 1'b0;
            dlen    <= 1'b1;
            bit_cnt <= '0;
        end else if (word_load && !busy) begin
            busy    <= 1'b1;  // word captured, frame opens next edge
            bit_cnt <= '0;
        end else if (busy && dlen) begin
            dlen <= 1'b0;
        end else if (!dlen) begin
            if (bit_cnt == LAST_BIT) begin
                dlen <= 1'b1;
                busy <= 1'b0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    a_no_load_when_busy : assert property (
        @(posedge slow_clk) disable iff (resetS)
        word_load |-> !busy
    );

    // frame never stretches past one word
    a_dlen_low_max : assert property (
        @(posedge slow_clk) disable iff (resetS)
        $fell(dlen) |-> ##[1:WW] dlen
    );

endmodule

/* src.f */
common/clk_synth_pkg.sv
cfg_regs/synth_reg_bank.sv
serial/word_shifter.sv
serial/program_sequencer.sv
rtl/clk_synth_top.sv
bench/tb_clk_synth.sv
